// File: files.f
source/alu_pkg.sv
source/alu_adder.sv
source/sequential_alu.sv
source/alu_sequencer.sv
source/alu_top.sv
test/tb_clock_gen.sv
test/alu_props.sv
test/alu_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module alu_tb -f files.f -o alu_sim \
   && ./obj_dir/alu_sim > sim.log 2>&1 \
   || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0

// File: source/alu_adder.sv
`timescale 1ns/1ps
module alu_adder #(
   parameter int DATA_WIDTH = 16
) (
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   output logic signed [DATA_WIDTH-1:0] o_q,
   output logic                         o_ovf
);

   logic sign_a;
   logic sign_b;
   logic sign_q;

   assign o_q = i_a + i_b;

   assign sign_a = i_a[DATA_WIDTH-1];
   assign sign_b = i_b[DATA_WIDTH-1];
   assign sign_q = o_q[DATA_WIDTH-1];

   // Operands agree in sign but the sum does not
   assign o_ovf = (sign_a == sign_b) && (sign_q != sign_a);

endmodule

// File: source/alu_pkg.sv
package alu_pkg;

   // Command opcodes
   typedef enum logic [1:0] {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_MUL = 2'd2,
      OP_DIV = 2'd3
   } alu_op_t;

   // Iterative ALU states
   typedef enum logic [2:0] {
      ST_IDLE    = 3'd0,
      ST_SIGN_B  = 3'd1,
      ST_SIGN_Q  = 3'd2,
      ST_MUL     = 3'd3,
      ST_DIV_R   = 3'd4,
      ST_DIV_CMP = 3'd5,
      ST_DIV_CNT = 3'd6
   } alu_state_t;

   // Command sequencer states
   typedef enum logic [1:0] {
      SEQ_IDLE = 2'd0,
      SEQ_RUN  = 2'd1,
      SEQ_DONE = 2'd2
   } seq_state_t;

endpackage

// File: source/alu_sequencer.sv
`timescale 1ns/1ps
module alu_sequencer #(
   parameter int DATA_WIDTH = 16
) (
   input  logic                         i_clk,
   input  logic                         i_nrst,
   input  logic                         i_start,
   input  alu_pkg::alu_op_t             i_op,
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   output logic                         o_add,
   output logic                         o_sub,
   output logic                         o_mul,
   output logic                         o_div,
   output logic signed [DATA_WIDTH-1:0] o_a,
   output logic signed [DATA_WIDTH-1:0] o_b,
   input  logic                         i_accept,
   input  logic signed [DATA_WIDTH-1:0] i_q,
   input  logic                         i_ovf,
   output logic                         o_busy,
   output logic                         o_done,
   output logic signed [DATA_WIDTH-1:0] o_result,
   output logic                         o_ovf,
   output logic                         o_div_zero
);

   alu_pkg::seq_state_t state;
   logic                div_by_zero;
   logic                take;

   assign div_by_zero = (i_op == alu_pkg::OP_DIV) && (i_b == '0);
   assign take        = i_start && !o_busy;

   assign o_busy = (state == alu_pkg::SEQ_RUN);
   assign o_done = (state == alu_pkg::SEQ_DONE);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state      <= alu_pkg::SEQ_IDLE;
         o_add      <= 1'b0;
         o_sub      <= 1'b0;
         o_mul      <= 1'b0;
         o_div      <= 1'b0;
         o_result   <= '0;
         o_ovf      <= 1'b0;
         o_div_zero <= 1'b0;
      end else begin
         case (state)
            alu_pkg::SEQ_IDLE, alu_pkg::SEQ_DONE: begin
               state <= alu_pkg::SEQ_IDLE;
               if (take && div_by_zero) begin
                  // Answered here, the ALU never sees it
                  state      <= alu_pkg::SEQ_DONE;
                  o_result   <= '0;
                  o_ovf      <= 1'b0;
                  o_div_zero <= 1'b1;
               end else if (take) begin
                  state <= alu_pkg::SEQ_RUN;
                  o_add <= (i_op == alu_pkg::OP_ADD);
                  o_sub <= (i_op == alu_pkg::OP_SUB);
                  o_mul <= (i_op == alu_pkg::OP_MUL);
                  o_div <= (i_op == alu_pkg::OP_DIV);
               end
            end
            alu_pkg::SEQ_RUN: begin
               if (i_accept) begin
                  state      <= alu_pkg::SEQ_DONE;
                  o_add      <= 1'b0;
                  o_sub      <= 1'b0;
                  o_mul      <= 1'b0;
                  o_div      <= 1'b0;
                  o_result   <= i_q;
                  o_ovf      <= i_ovf;
                  o_div_zero <= 1'b0;
               end
            end
            default: state <= alu_pkg::SEQ_IDLE;
         endcase
      end
   end

   // Operands held for the whole ALU run
   always_ff @(posedge i_clk) begin
      if (take) begin
         o_a <= i_a;
         o_b <= i_b;
      end
   end

endmodule

// File: source/alu_top.sv
`timescale 1ns/1ps
module alu_top #(
   parameter int DATA_WIDTH = 16
) (
   input  logic                         i_clk,
   input  logic                         i_nrst,
   input  logic                         i_start,
   input  alu_pkg::alu_op_t             i_op,
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   output logic                         o_busy,
   output logic                         o_done,
   output logic signed [DATA_WIDTH-1:0] o_result,
   output logic                         o_ovf,
   output logic                         o_div_zero
);

   logic                         add;
   logic                         sub;
   logic                         mul;
   logic                         div;
   logic signed [DATA_WIDTH-1:0] a;
   logic signed [DATA_WIDTH-1:0] b;
   logic signed [DATA_WIDTH-1:0] q;
   logic                         ovf;
   logic                         accept;

   alu_sequencer #(
      .DATA_WIDTH (DATA_WIDTH)
   ) u_seq (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_start    (i_start),
      .i_op       (i_op),
      .i_a        (i_a),
      .i_b        (i_b),
      .o_add      (add),
      .o_sub      (sub),
      .o_mul      (mul),
      .o_div      (div),
      .o_a        (a),
      .o_b        (b),
      .i_accept   (accept),
      .i_q        (q),
      .i_ovf      (ovf),
      .o_busy     (o_busy),
      .o_done     (o_done),
      .o_result   (o_result),
      .o_ovf      (o_ovf),
      .o_div_zero (o_div_zero)
   );

   sequential_alu #(
      .DATA_WIDTH (DATA_WIDTH)
   ) u_alu (
      .i_clk    (i_clk),
      .i_nrst   (i_nrst),
      .i_a      (a),
      .i_b      (b),
      .i_add    (add),
      .i_sub    (sub),
      .i_mul    (mul),
      .i_div    (div),
      .o_q      (q),
      .o_ovf    (ovf),
      .o_accept (accept)
   );

endmodule

// File: source/sequential_alu.sv
`timescale 1ns/1ps
module sequential_alu #(
   parameter int DATA_WIDTH = 16
) (
   input  logic                         i_clk,
   input  logic                         i_nrst,
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   input  logic                         i_add,
   input  logic                         i_sub,
   input  logic                         i_mul,
   input  logic                         i_div,
   output logic signed [DATA_WIDTH-1:0] o_q,
   output logic                         o_ovf,
   output logic                         o_accept
);

   localparam int CNT_W = $clog2(DATA_WIDTH);

   typedef logic signed [DATA_WIDTH-1:0] word_t;
   typedef logic [CNT_W-1:0]             count_t;

   localparam word_t  MIN_VAL  = {1'b1, {(DATA_WIDTH-1){1'b0}}};
   localparam word_t  ONE      = word_t'(1);
   localparam count_t LAST_CNT = count_t'(DATA_WIDTH-1);

   alu_pkg::alu_state_t state;
   alu_pkg::alu_state_t first_state;

   // Magnitudes, partial remainder and bit counter
   word_t  a;
   word_t  b;
   word_t  r;
   count_t cnt;
   logic   neg;

   word_t  add_a;
   word_t  add_b;
   word_t  adder_q;
   logic   adder_ovf;

   logic   a_top;
   logic   b_top;
   logic   a_min;
   logic   b_min;
   logic   a_last;
   logic   mul_ovf;
   logic   trial_ok;

   assign a_top    = i_a[DATA_WIDTH-1];
   assign b_top    = i_b[DATA_WIDTH-1];
   assign a_min    = (i_a == MIN_VAL);
   assign b_min    = (i_b == MIN_VAL);
   assign a_last   = (a[DATA_WIDTH-1:1] == '0);
   assign mul_ovf  = b[DATA_WIDTH-1] | (a[0] & adder_ovf);
   // Sign of b - r - 1 set means r >= b
   assign trial_ok = adder_q[DATA_WIDTH-1];

   always_comb begin
      if (i_mul) begin
         first_state = alu_pkg::ST_MUL;
      end else begin
         first_state = alu_pkg::ST_DIV_R;
      end
   end

   // Shared adder input steering
   always_comb begin
      add_a = i_a;
      add_b = i_b;
      case (state)
         alu_pkg::ST_IDLE: begin
            if (i_sub) begin
               // a - b computed as ~(~a + b)
               add_a = ~i_a;
            end else if (i_mul | i_div) begin
               add_a = a_top ? ~i_a : ~i_b;
               add_b = ONE;
            end
         end
         alu_pkg::ST_SIGN_B: begin
            add_a = ~b;
            add_b = ONE;
         end
         alu_pkg::ST_SIGN_Q: begin
            add_a = ~o_q;
            add_b = ONE;
         end
         alu_pkg::ST_MUL: begin
            add_a = o_q;
            add_b = b;
         end
         alu_pkg::ST_DIV_CMP: begin
            add_a = ~r;
            add_b = b;
         end
         alu_pkg::ST_DIV_CNT: begin
            add_a = {{(DATA_WIDTH-CNT_W){1'b0}}, cnt};
            add_b = ONE;
         end
         default: ;
      endcase
   end

   alu_adder #(
      .DATA_WIDTH (DATA_WIDTH)
   ) u_adder (
      .i_a   (add_a),
      .i_b   (add_b),
      .o_q   (adder_q),
      .o_ovf (adder_ovf)
   );

   // Control path
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state    <= alu_pkg::ST_IDLE;
         o_accept <= 1'b0;
         o_ovf    <= 1'b0;
         neg      <= 1'b0;
      end else begin
         o_accept <= 1'b0;
         o_ovf    <= 1'b0;
         case (state)
            alu_pkg::ST_IDLE: begin
               // Levels are still up during the accept cycle
               if (!o_accept) begin
                  if (i_add) begin
                     o_accept <= 1'b1;
                     o_ovf    <= adder_ovf;
                  end else if (i_sub) begin
                     o_accept <= 1'b1;
                     o_ovf    <= adder_ovf | b_min;
                  end else if (i_mul | i_div) begin
                     neg <= a_top ^ b_top;
                     if (a_min | b_min) begin
                        o_accept <= 1'b1;
                        o_ovf    <= 1'b1;
                     end else if (a_top & b_top) begin
                        state <= alu_pkg::ST_SIGN_B;
                     end else begin
                        state <= first_state;
                     end
                  end
               end
            end
            alu_pkg::ST_SIGN_B: begin
               state <= first_state;
            end
            alu_pkg::ST_SIGN_Q: begin
               o_accept <= 1'b1;
               state    <= alu_pkg::ST_IDLE;
            end
            alu_pkg::ST_MUL: begin
               if (mul_ovf) begin
                  o_accept <= 1'b1;
                  o_ovf    <= 1'b1;
                  state    <= alu_pkg::ST_IDLE;
               end else if (a_last) begin
                  if (neg) begin
                     state <= alu_pkg::ST_SIGN_Q;
                  end else begin
                     o_accept <= 1'b1;
                     state    <= alu_pkg::ST_IDLE;
                  end
               end
            end
            alu_pkg::ST_DIV_R: begin
               state <= alu_pkg::ST_DIV_CMP;
            end
            alu_pkg::ST_DIV_CMP: begin
               state <= alu_pkg::ST_DIV_CNT;
            end
            alu_pkg::ST_DIV_CNT: begin
               if (cnt != LAST_CNT) begin
                  state <= alu_pkg::ST_DIV_R;
               end else if (neg) begin
                  state <= alu_pkg::ST_SIGN_Q;
               end else begin
                  o_accept <= 1'b1;
                  state    <= alu_pkg::ST_IDLE;
               end
            end
            default: state <= alu_pkg::ST_IDLE;
         endcase
      end
   end

   // Datapath
   always_ff @(posedge i_clk) begin
      case (state)
         alu_pkg::ST_IDLE: begin
            if (!o_accept) begin
               if (i_add) begin
                  o_q <= adder_q;
               end else if (i_sub) begin
                  o_q <= ~adder_q;
               end else if (i_mul | i_div) begin
                  o_q <= '0;
                  r   <= '0;
                  cnt <= '0;
                  a   <= a_top ? adder_q : i_a;
                  b   <= (b_top & ~a_top) ? adder_q : i_b;
               end
            end
         end
         alu_pkg::ST_SIGN_B: b <= adder_q;
         alu_pkg::ST_SIGN_Q: o_q <= adder_q;
         alu_pkg::ST_MUL: begin
            a <= a >> 1;
            b <= b << 1;
            if (a[0]) begin
               o_q <= adder_q;
            end
         end
         alu_pkg::ST_DIV_R: begin
            r <= {r[DATA_WIDTH-2:0], a[DATA_WIDTH-1]};
            a <= a << 1;
         end
         alu_pkg::ST_DIV_CMP: begin
            // Restore skipped when the trial goes negative
            if (trial_ok) begin
               r <= ~adder_q;
            end
            o_q <= {o_q[DATA_WIDTH-2:0], trial_ok};
         end
         alu_pkg::ST_DIV_CNT: cnt <= adder_q[CNT_W-1:0];
         default: ;
      endcase
   end

endmodule

// File: test/alu_props.sv
`timescale 1ns/1ps
module alu_props (
   input logic                i_clk,
   input logic                i_nrst,
   input alu_pkg::seq_state_t i_state,
   input logic                i_busy,
   input logic                i_done,
   input logic                i_add,
   input logic                i_sub,
   input logic                i_mul,
   input logic                i_div
);

   // Done is a single-cycle strobe
   a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !(i_done && $past(i_done)))
      else $error("o_done high on two consecutive cycles");

   // Levels already dropped when the result is reported
   a_done_not_busy: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_done |-> (!i_busy && !(i_add || i_sub || i_mul || i_div)))
      else $error("o_busy or an operation level high during o_done");

   // Operation levels are one-hot or all low, and held through the run
   a_levels_onehot: assert property (@(posedge i_clk) disable iff (!i_nrst)
      $onehot0({i_add, i_sub, i_mul, i_div}) &&
      (i_state != alu_pkg::SEQ_RUN || $onehot({i_add, i_sub, i_mul, i_div})))
      else $error("operation levels not one-hot or not held during the run");

endmodule

bind alu_sequencer alu_props u_props (
   .i_clk   (i_clk),
   .i_nrst  (i_nrst),
   .i_state (state),
   .i_busy  (o_busy),
   .i_done  (o_done),
   .i_add   (o_add),
   .i_sub   (o_sub),
   .i_mul   (o_mul),
   .i_div   (o_div)
);

// File: test/alu_tb.sv
`timescale 1ns/1ps
module alu_tb;

   localparam int DATA_WIDTH    = 16;
   localparam int CLK_PERIOD_NS = 4;
   localparam int RESET_CYCLES  = 4;
   localparam int DONE_LIMIT    = 80;
   localparam int N_DIRECTED    = 30;
   localparam int N_RANDOM      = 40;
   localparam int N_ROWS        = N_DIRECTED + N_RANDOM + 2;
   localparam int WATCHDOG_NS   = N_ROWS * 80 * CLK_PERIOD_NS;
   localparam int MAX_INT       = 2 ** (DATA_WIDTH - 1) - 1;
   localparam int MIN_INT       = -(2 ** (DATA_WIDTH - 1));

   typedef logic signed [DATA_WIDTH-1:0] word_t;

   typedef struct packed {
      alu_pkg::alu_op_t op;
      word_t            a;
      word_t            b;
   } row_t;

   // Opcode, a, b
   localparam row_t DIRECTED [N_DIRECTED] = '{
      '{alu_pkg::OP_ADD, 16'sd100, 16'sd23},
      '{alu_pkg::OP_ADD, -16'sd5, 16'sd3},
      '{alu_pkg::OP_ADD, 16'sd32767, 16'sd1},
      '{alu_pkg::OP_ADD, 16'sh8000, -16'sd1},
      '{alu_pkg::OP_ADD, -16'sd20000, 16'sd20000},
      '{alu_pkg::OP_SUB, 16'sd50, 16'sd80},
      '{alu_pkg::OP_SUB, 16'sh8000, 16'sd1},
      '{alu_pkg::OP_SUB, 16'sd0, 16'sh8000},
      '{alu_pkg::OP_SUB, -16'sd1, 16'sh8000},
      '{alu_pkg::OP_SUB, 16'sd1000, -16'sd1000},
      '{alu_pkg::OP_MUL, 16'sd123, 16'sd45},
      '{alu_pkg::OP_MUL, -16'sd123, 16'sd45},
      '{alu_pkg::OP_MUL, 16'sd123, -16'sd45},
      '{alu_pkg::OP_MUL, -16'sd123, -16'sd45},
      '{alu_pkg::OP_MUL, 16'sd0, -16'sd7},
      '{alu_pkg::OP_MUL, 16'sd200, 16'sd200},
      '{alu_pkg::OP_MUL, -16'sd256, 16'sd128},
      '{alu_pkg::OP_MUL, 16'sh8000, 16'sd1},
      '{alu_pkg::OP_MUL, 16'sd1, 16'sh8000},
      '{alu_pkg::OP_MUL, 16'sd181, 16'sd181},
      '{alu_pkg::OP_DIV, 16'sd100, 16'sd7},
      '{alu_pkg::OP_DIV, -16'sd100, 16'sd7},
      '{alu_pkg::OP_DIV, 16'sd100, -16'sd7},
      '{alu_pkg::OP_DIV, -16'sd100, -16'sd7},
      '{alu_pkg::OP_DIV, 16'sd3, 16'sd5},
      '{alu_pkg::OP_DIV, 16'sh8000, 16'sd3},
      '{alu_pkg::OP_DIV, 16'sd5, 16'sh8000},
      '{alu_pkg::OP_DIV, 16'sd32767, 16'sd1},
      '{alu_pkg::OP_DIV, 16'sd42, 16'sd0},
      '{alu_pkg::OP_DIV, -16'sd1, 16'sd0}
   };

   logic             clk;
   logic             nrst;
   logic             start;
   alu_pkg::alu_op_t cmd_op;
   word_t            cmd_a;
   word_t            cmd_b;
   logic             busy;
   logic             done;
   word_t            result;
   logic             ovf;
   logic             div_zero;

   int               word_errors;
   int               flag_errors;
   int               count_errors;
   int               other_errors;
   logic [31:0]      seed;

   tb_clock_gen #(
      .PERIOD_NS (CLK_PERIOD_NS)
   ) u_clock_gen (
      .o_clk (clk)
   );

   alu_top #(
      .DATA_WIDTH (DATA_WIDTH)
   ) u_alu_top (
      .i_clk      (clk),
      .i_nrst     (nrst),
      .i_start    (start),
      .i_op       (cmd_op),
      .i_a        (cmd_a),
      .i_b        (cmd_b),
      .o_busy     (busy),
      .o_done     (done),
      .o_result   (result),
      .o_ovf      (ovf),
      .o_div_zero (div_zero)
   );

   function automatic logic [31:0] next_random(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Expected values straight from the result rules
   function automatic void ref_model(input alu_pkg::alu_op_t op, input word_t a,
                                     input word_t b, output word_t res,
                                     output logic exp_ovf, output logic exp_dz);
      int ia;
      int ib;
      int exact;
      ia      = int'(a);
      ib      = int'(b);
      exact   = 0;
      exp_ovf = 1'b0;
      exp_dz  = 1'b0;
      case (op)
         alu_pkg::OP_ADD: begin
            exact   = ia + ib;
            exp_ovf = (exact > MAX_INT) || (exact < MIN_INT);
         end
         alu_pkg::OP_SUB: begin
            exact   = ia - ib;
            exp_ovf = (exact > MAX_INT) || (exact < MIN_INT) || (ib == MIN_INT);
         end
         alu_pkg::OP_MUL: begin
            exact   = ia * ib;
            exp_ovf = (ia == MIN_INT) || (ib == MIN_INT) || (exact > MAX_INT) ||
                      (exact < -MAX_INT);
         end
         default: begin
            if (ib == 0) begin
               exp_dz = 1'b1;
            end else begin
               exp_ovf = (ia == MIN_INT) || (ib == MIN_INT);
               exact   = ia / ib;
            end
         end
      endcase
      res = exact[DATA_WIDTH-1:0];
   endfunction

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("Error at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
         word_errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("Error at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
         flag_errors++;
      end
   endtask

   task automatic check_count(input string name, input int expected, input int actual);
      if (actual != expected) begin
         $display("Error at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
         count_errors++;
      end
   endtask

   // One-cycle start strobe
   task automatic issue_start(input alu_pkg::alu_op_t op, input word_t a, input word_t b);
      @(posedge clk);
      start  <= 1'b1;
      cmd_op <= op;
      cmd_a  <= a;
      cmd_b  <= b;
      @(posedge clk);
      start  <= 1'b0;
   endtask

   // Cycles counted from the end of the start cycle
   task automatic wait_done(output int cycles);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!done && cycles < DONE_LIMIT);
      if (!done) begin
         $display("Error at %0d ns: no o_done within %0d cycles", $time, DONE_LIMIT);
         other_errors++;
         cycles = -1;
      end
   endtask

   task automatic apply_row(input alu_pkg::alu_op_t op, input word_t a, input word_t b);
      word_t exp_res;
      logic  exp_ovf;
      logic  exp_dz;
      int    cycles;
      ref_model(op, a, b, exp_res, exp_ovf, exp_dz);
      issue_start(op, a, b);
      wait_done(cycles);
      if (cycles > 0) begin
         if (!exp_ovf) begin
            check_word("o_result", exp_res, result);
         end
         check_flag("o_ovf", exp_ovf, ovf);
         check_flag("o_div_zero", exp_dz, div_zero);
         if (exp_dz) begin
            check_count("o_done latency", 1, cycles);
         end else if (op == alu_pkg::OP_ADD || op == alu_pkg::OP_SUB) begin
            check_count("o_done latency", 3, cycles);
         end
      end
   endtask

   // Second start lands while the divide is running
   task automatic busy_start_test();
      int cycles;
      int extra;
      extra = 0;
      issue_start(alu_pkg::OP_DIV, 16'sd1000, 16'sd7);
      @(negedge clk);
      check_flag("o_busy", 1'b1, busy);
      @(posedge clk);
      start  <= 1'b1;
      cmd_op <= alu_pkg::OP_ADD;
      cmd_a  <= 16'sd1;
      cmd_b  <= 16'sd2;
      @(posedge clk);
      start  <= 1'b0;
      wait_done(cycles);
      if (cycles > 0) begin
         check_word("o_result", 16'sd142, result);
         check_flag("o_ovf", 1'b0, ovf);
      end
      repeat (20) begin
         @(negedge clk);
         if (done) begin
            extra++;
         end
      end
      check_count("o_done strobes after dropped start", 0, extra);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Error at %0d ns: watchdog expired before the tests ended", $time);
      $display("Test failed");
      $finish;
   end

   initial begin
      alu_pkg::alu_op_t op;
      word_t            a;
      word_t            b;
      word_errors  = 0;
      flag_errors  = 0;
      count_errors = 0;
      other_errors = 0;
      seed         = 32'h94549da9;
      nrst   <= 1'b0;
      start  <= 1'b0;
      cmd_op <= alu_pkg::OP_ADD;
      cmd_a  <= '0;
      cmd_b  <= '0;
      repeat (RESET_CYCLES) @(posedge clk);
      nrst <= 1'b1;
      @(negedge clk);
      check_flag("o_busy", 1'b0, busy);
      check_flag("o_done", 1'b0, done);
      check_word("o_result", '0, result);
      for (int i = 0; i < N_DIRECTED; i++) begin
         apply_row(DIRECTED[i].op, DIRECTED[i].a, DIRECTED[i].b);
      end
      busy_start_test();
      for (int i = 0; i < N_RANDOM; i++) begin
         seed = next_random(seed);
         op   = alu_pkg::alu_op_t'(seed[31:30]);
         seed = next_random(seed);
         a    = seed[31:16];
         seed = next_random(seed);
         b    = seed[31:16];
         // Byte-sized operands keep products and quotients away from overflow
         if (op == alu_pkg::OP_MUL || op == alu_pkg::OP_DIV) begin
            b = {{(DATA_WIDTH-8){b[7]}}, b[7:0]};
         end
         if (op == alu_pkg::OP_MUL) begin
            a = {{(DATA_WIDTH-8){a[7]}}, a[7:0]};
         end
         apply_row(op, a, b);
      end
      $display("Errors: result %0d, flag %0d, count %0d, other %0d",
               word_errors, flag_errors, count_errors, other_errors);
      if (word_errors + flag_errors + count_errors + other_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
module tb_clock_gen #(
   parameter int PERIOD_NS = 4
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
   end

   always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule
